// ==== sample_discriminator.f ====
design/disc_types_pkg.sv
design/disc_config_pkg.sv
design/hysteresis_trigger.sv
design/trigger_router.sv
design/sample_history.sv
design/discriminator_ctrl.sv
design/sample_discriminator.sv
verification/sample_discriminator_assertions.sv
verification/sample_discriminator_tb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = sample_discriminator_tb
FILELIST = sample_discriminator.f
SIMFLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) -f $(FILELIST)

run: $(BIN)
	$(BIN) | awk '{ print } /ALL TESTS PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/sample_discriminator_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the discriminator, random samples against a window model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sample_discriminator_tb;

  import disc_types_pkg::*;
  import disc_config_pkg::*;

  localparam int MAX_DELAY = 16;
  localparam int LAT = MAX_DELAY + 1;
  localparam int RESET_CYCLES = 16;
  localparam int FIRST_EDGE = RESET_CYCLES + 1;
  localparam int RUN_LEN = 120;
  localparam int TEST_CYCLES = RESET_CYCLES + 60 + 6 * (RUN_LEN + 1) + 61 + 40;
  localparam int TIMEOUT = TEST_CYCLES + 200;
  localparam int DEPTH = TEST_CYCLES + 64;

  logic                    adc_clk;
  logic                    reset_i;
  logic                    reset_state_i;
  logic                    cfg_load_i;
  sample_vec_t             samples_i;
  logic [DIG_CHANNELS-1:0] digital_trigger_i;
  disc_cfg_t               cfg_i;
  sample_vec_t             data_o;
  logic [CHANNELS-1:0]     data_valid_o;
  stamp_vec_t              stamps_o;
  logic [CHANNELS-1:0]     stamp_valid_o;

  // reference model state, indexed by the edge that samples the inputs
  sample_vec_t             samp_a [DEPTH];
  index_t                  idx_a [DEPTH];
  logic [CHANNELS-1:0]     sel_a [DEPTH];
  logic [DIG_CHANNELS-1:0] dig_a [DEPTH];
  int                      epoch_a [DEPTH];
  int                      seg_a [DEPTH];
  logic                    segrs_a [DEPTH];
  disc_cfg_t               cfgs [8];
  disc_cfg_t               cur_cfg;
  disc_cfg_t               pending_cfg;
  logic [CHANNELS-1:0]     hyst_q;
  logic [31:0]             lfsr_q;
  int                      edge_no;
  int                      epoch;
  int                      idx_cnt;
  int                      seg_cur;
  logic                    seg_rs;
  int                      cycle_cnt = 0;

  sample_discriminator #(.MAX_DELAY_CYCLES(MAX_DELAY)) UUT (.*);

  bind sample_discriminator sample_discriminator_assertions #(
    .MAX_DELAY_CYCLES(MAX_DELAY_CYCLES)
  ) u_assertions (
    .adc_clk       (adc_clk),
    .reset_i       (reset_i),
    .reset_state_i (reset_state_i),
    .cfg_i         (cfg),
    .hist_valid_i  (hist_valid),
    .data_valid_i  (data_valid_o),
    .stamp_valid_i (stamp_valid_o)
  );

  always #10 adc_clk = ~adc_clk;

  always @(posedge adc_clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic disc_cfg_t build_cfg(input int low, input int high, input int start,
                                          input int stop, input bit digital);
    disc_cfg_t cfg;
    cfg = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      cfg.low_threshold[c] = sample_t'(low);
      cfg.high_threshold[c] = sample_t'(high);
      cfg.start_delay[c] = delay_t'(start);
      cfg.stop_delay[c] = delay_t'(stop);
      if (digital) begin
        cfg.trigger_source[c] = src_t'(CHANNELS + c % 2);
        cfg.digital_delay[c] = delay_t'((c % 2) * 3);
      end else begin
        cfg.trigger_source[c] = src_t'(c);
      end
    end
    return cfg;
  endfunction

  // keep rule, a trigger within stop_delay before or start_delay after
  function automatic logic kept(input int n, input int c);
    disc_cfg_t cfg;
    int st;
    int lo;
    cfg = cfgs[epoch_a[n + LAT - 1]];
    st = int'(cfg.start_delay[c]);
    lo = n - int'(cfg.stop_delay[c]);
    if (cfg.disable_bit[c]) return 1'b1;
    if (sel_a[n + st][c]) return 1'b1;
    // triggers seen before a reset_state do not hold the window open
    if (segrs_a[n] && lo < seg_a[n] + st) lo = seg_a[n] + st;
    for (int m = lo; m < n + st; m++) begin
      if (m >= 1 && sel_a[m][c]) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic value_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("Fail %s expected %h got %h", name, expected, actual);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic record_edge(input int e);
    int src;
    int tap;
    samp_a[e] = samples_i;
    dig_a[e] = '0;
    sel_a[e] = '0;
    if (reset_i) begin
      hyst_q = '0;
      idx_cnt = 0;
      seg_cur = e + 1;
      seg_rs = 1'b0;
    end else begin
      if (reset_state_i) begin
        hyst_q = '0;
        idx_cnt = 0;
        seg_cur = e;
        seg_rs = 1'b1;
      end
      idx_a[e] = index_t'(idx_cnt);
      idx_cnt++;
      dig_a[e] = digital_trigger_i;
      // thresholds of the config in force before this edge
      for (int c = 0; c < CHANNELS; c++) begin
        if ($signed(samples_i[c]) > $signed(cur_cfg.high_threshold[c])) begin
          hyst_q[c] = 1'b1;
        end else if ($signed(samples_i[c]) < $signed(cur_cfg.low_threshold[c])) begin
          hyst_q[c] = 1'b0;
        end
      end
    end
    if (cfg_load_i) begin
      cur_cfg = cfg_i;
      epoch++;
      cfgs[epoch] = cur_cfg;
    end
    epoch_a[e] = epoch;
    seg_a[e] = seg_cur;
    segrs_a[e] = seg_rs;
    for (int c = 0; c < CHANNELS; c++) begin
      src = int'(cur_cfg.trigger_source[c]);
      tap = e - int'(cur_cfg.digital_delay[c]);
      if (reset_i) begin
        sel_a[e][c] = 1'b0;
      end else if (src < CHANNELS) begin
        sel_a[e][c] = hyst_q[src];
      end else if (src < CHANNELS + DIG_CHANNELS && tap >= 1) begin
        sel_a[e][c] = dig_a[tap][src - CHANNELS];
      end
    end
  endtask

  task automatic apply(input logic rst, input logic rs, input logic load);
    logic [31:0] v;
    reset_i = rst;
    reset_state_i = rs;
    cfg_load_i = load;
    cfg_i = pending_cfg;
    for (int c = 0; c < CHANNELS; c++) begin
      v = take_bits(6);
      samples_i[c] = sample_t'({{(SAMPLE_WIDTH - 6){v[5]}}, v[5:0]});
    end
    // sparse digital triggers, one in eight
    for (int d = 0; d < DIG_CHANNELS; d++) begin
      v = take_bits(3);
      digital_trigger_i[d] = &v[2:0];
    end
    record_edge(edge_no + 1);
  endtask

  task automatic check_outputs();
    int n;
    int lo;
    logic exp_keep;
    logic exp_stamp;
    n = edge_no - LAT;
    lo = (n - 22 < 1) ? 1 : n - 22;
    if (n < FIRST_EDGE) begin
      if (data_valid_o !== '0) value_mismatch("data_valid_o", 32'(0), 32'(data_valid_o));
      if (stamp_valid_o !== '0) value_mismatch("stamp_valid_o", 32'(0), 32'(stamp_valid_o));
    end else if (epoch_a[lo] == epoch_a[n + LAT - 1]) begin
      // only samples whose whole window saw one configuration
      for (int c = 0; c < CHANNELS; c++) begin
        exp_keep = kept(n, c);
        exp_stamp = exp_keep & ~cfgs[epoch_a[n + LAT - 1]].disable_bit[c]
                    & ((n == seg_a[n]) | ~kept(n - 1, c));
        if (data_valid_o[c] !== exp_keep)
          value_mismatch($sformatf("data_valid_o[%0d]", c), 32'(exp_keep),
                         32'(data_valid_o[c]));
        if (stamp_valid_o[c] !== exp_stamp)
          value_mismatch($sformatf("stamp_valid_o[%0d]", c), 32'(exp_stamp),
                         32'(stamp_valid_o[c]));
        if (exp_keep && data_o[c] !== samp_a[n][c])
          value_mismatch($sformatf("data_o[%0d]", c), 32'(samp_a[n][c]), 32'(data_o[c]));
        if (exp_stamp && stamps_o[c] !== idx_a[n])
          value_mismatch($sformatf("stamps_o[%0d]", c), idx_a[n], stamps_o[c]);
      end
    end
  endtask

  task automatic tick(input logic rst, input logic rs, input logic load);
    @(posedge adc_clk);
    edge_no++;
    #1;
    check_outputs();
    apply(rst, rs, load);
  endtask

  task automatic run_cycles(input int n);
    repeat (n) tick(1'b0, 1'b0, 1'b0);
  endtask

  task automatic load_config(input disc_cfg_t cfg);
    pending_cfg = cfg;
    tick(1'b0, 1'b0, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////
  initial begin
    adc_clk = 1'b0;
    lfsr_q = 32'hf6f763d4;
    edge_no = 0;
    epoch = 0;
    idx_cnt = 0;
    seg_cur = 1;
    seg_rs = 1'b0;
    hyst_q = '0;
    cur_cfg = '0;
    cur_cfg.disable_bit = '1;
    cfgs[0] = cur_cfg;
    pending_cfg = '0;
    apply(1'b1, 1'b0, 1'b0);
    repeat (RESET_CYCLES - 1) tick(1'b1, 1'b0, 1'b0);
    // reset config disables every channel
    run_cycles(60);
    load_config(build_cfg(19, 25, 0, 0, 1'b0));
    run_cycles(RUN_LEN);
    load_config(build_cfg(19, 25, 5, 1, 1'b0));
    run_cycles(RUN_LEN);
    load_config(build_cfg(19, 25, 0, 7, 1'b0));
    run_cycles(RUN_LEN);
    load_config(build_cfg(19, 25, 2, 2, 1'b1));
    run_cycles(RUN_LEN);
    // reset_state in the middle of a run
    load_config(build_cfg(19, 25, 3, 2, 1'b0));
    run_cycles(60);
    tick(1'b0, 1'b1, 1'b0);
    run_cycles(RUN_LEN);
    load_config(build_cfg(-5, 10, 2, 3, 1'b0));
    run_cycles(RUN_LEN);
    run_cycles(40);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== verification/sample_discriminator_assertions.sv ====
//////////////////////////////////////////////////////////////////////
// concurrent checks on the discriminator outputs
// attached to the top level with bind
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sample_discriminator_assertions #(
  parameter int MAX_DELAY_CYCLES = 16
) (
  input logic                                adc_clk,
  input logic                                reset_i,
  input logic                                reset_state_i,
  input disc_config_pkg::disc_cfg_t          cfg_i,
  input logic                                hist_valid_i,
  input logic [disc_types_pkg::CHANNELS-1:0] data_valid_i,
  input logic [disc_types_pkg::CHANNELS-1:0] stamp_valid_i
);

  import disc_types_pkg::*;

  // edges from the one that takes a reset_state sample to the one
  // that samples the registered output of that sample
  localparam int LAT = MAX_DELAY_CYCLES + 2;

  for (genvar c = 0; c < CHANNELS; c++) begin : g_chan
    // disabled channel passes every sample without a stamp
    disabled_passthrough: assert property (@(posedge adc_clk) disable iff (reset_i)
      $past(cfg_i.disable_bit[c] & hist_valid_i) |-> data_valid_i[c] && !stamp_valid_i[c])
      else $error("disabled channel %0d dropped a sample or stamped it", c);

    // a stamp right after a kept sample needs a reset_state in between
    stamp_after_gap: assert property (@(posedge adc_clk) disable iff (reset_i)
      stamp_valid_i[c] && $past(data_valid_i[c]) |-> $past(reset_state_i, LAT))
      else $error("channel %0d stamped a sample that continues a window", c);
  end

  stamp_needs_data: assert property (@(posedge adc_clk) disable iff (reset_i)
    (stamp_valid_i & ~data_valid_i) == '0)
    else $error("stamp valid without data valid");

  quiet_in_reset: assert property (@(posedge adc_clk)
    reset_i |=> data_valid_i == '0 && stamp_valid_i == '0)
    else $error("outputs active during reset");

endmodule

// ==== design/sample_discriminator.sv ====
//////////////////////////////////////////////////////////////////////
// multichannel adc sample discriminator, top level
// samples leave MAX_DELAY_CYCLES+2 cycles after they enter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sample_discriminator #(
  parameter int MAX_DELAY_CYCLES = 16
) (
  input  logic                                    adc_clk,
  input  logic                                    reset_i,
  input  disc_types_pkg::sample_vec_t             samples_i,
  input  logic [disc_types_pkg::DIG_CHANNELS-1:0] digital_trigger_i,
  input  logic                                    reset_state_i,
  input  disc_config_pkg::disc_cfg_t              cfg_i,
  input  logic                                    cfg_load_i,
  output disc_types_pkg::sample_vec_t             data_o,
  output logic [disc_types_pkg::CHANNELS-1:0]     data_valid_o,
  output disc_types_pkg::stamp_vec_t              stamps_o,
  output logic [disc_types_pkg::CHANNELS-1:0]     stamp_valid_o
);

  import disc_types_pkg::*;
  import disc_config_pkg::*;

  disc_cfg_t           cfg;
  logic [CHANNELS-1:0] analog_trig;
  logic [CHANNELS-1:0] sel_trig;
  hist_t               hist_out;
  logic                hist_valid;

  hysteresis_trigger u_hysteresis_trigger (
    .adc_clk          (adc_clk),
    .reset_i          (reset_i),
    .reset_state_i    (reset_state_i),
    .samples_i        (samples_i),
    .low_threshold_i  (cfg.low_threshold),
    .high_threshold_i (cfg.high_threshold),
    .analog_trig_o    (analog_trig)
  );

  trigger_router #(.MAX_DELAY_CYCLES(MAX_DELAY_CYCLES)) u_trigger_router (
    .adc_clk           (adc_clk),
    .reset_i           (reset_i),
    .digital_trigger_i (digital_trigger_i),
    .analog_trig_i     (analog_trig),
    .digital_delay_i   (cfg.digital_delay),
    .trigger_source_i  (cfg.trigger_source),
    .sel_trig_o        (sel_trig)
  );

  sample_history #(.MAX_DELAY_CYCLES(MAX_DELAY_CYCLES)) u_sample_history (
    .adc_clk       (adc_clk),
    .reset_i       (reset_i),
    .reset_state_i (reset_state_i),
    .samples_i     (samples_i),
    .hist_o        (hist_out),
    .hist_valid_o  (hist_valid)
  );

  discriminator_ctrl #(.MAX_DELAY_CYCLES(MAX_DELAY_CYCLES)) u_discriminator_ctrl (
    .adc_clk       (adc_clk),
    .reset_i       (reset_i),
    .reset_state_i (reset_state_i),
    .cfg_i         (cfg_i),
    .cfg_load_i    (cfg_load_i),
    .cfg_o         (cfg),
    .sel_trig_i    (sel_trig),
    .hist_i        (hist_out),
    .hist_valid_i  (hist_valid),
    .data_o        (data_o),
    .data_valid_o  (data_valid_o),
    .stamps_o      (stamps_o),
    .stamp_valid_o (stamp_valid_o)
  );

endmodule

// ==== design/discriminator_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// configuration register, trigger window and timestamp generation
// decides per channel which delayed samples leave the discriminator
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module discriminator_ctrl #(
  parameter int MAX_DELAY_CYCLES = 16
) (
  input  logic                                adc_clk,
  input  logic                                reset_i,
  input  logic                                reset_state_i,
  input  disc_config_pkg::disc_cfg_t          cfg_i,
  input  logic                                cfg_load_i,
  output disc_config_pkg::disc_cfg_t          cfg_o,
  input  logic [disc_types_pkg::CHANNELS-1:0] sel_trig_i,
  input  disc_types_pkg::hist_t               hist_i,
  input  logic                                hist_valid_i,
  output disc_types_pkg::sample_vec_t         data_o,
  output logic [disc_types_pkg::CHANNELS-1:0] data_valid_o,
  output disc_types_pkg::stamp_vec_t          stamps_o,
  output logic [disc_types_pkg::CHANNELS-1:0] stamp_valid_o
);

  import disc_types_pkg::*;
  import disc_config_pkg::*;

  localparam int TAP_W = $clog2(MAX_DELAY_CYCLES + 1);

  // start plus stop needs one more bit than a single delay
  typedef logic [TIMER_BITS:0] hold_t;

  disc_cfg_t cfg_q;

  // tap k holds the trigger of the sample k+1 cycles behind sel_trig_i
  logic [MAX_DELAY_CYCLES-1:0][CHANNELS-1:0] trig_q;
  logic [MAX_DELAY_CYCLES:0][CHANNELS-1:0]   trig_taps;
  // reset_state marker travelling in step with hist_i
  logic [MAX_DELAY_CYCLES:0]                 rs_q;
  logic                                      first;

  hold_t [CHANNELS-1:0]            hold_q;
  hold_t [CHANNELS-1:0]            hold_d;
  logic  [CHANNELS-1:0][TAP_W-1:0] tap_idx;
  logic  [CHANNELS-1:0]            tapped;
  logic  [CHANNELS-1:0]            keep;
  logic  [CHANNELS-1:0]            stamp;
  logic  [CHANNELS-1:0]            prev_keep_q;

  assign trig_taps = {trig_q, sel_trig_i};
  assign first = rs_q[MAX_DELAY_CYCLES];
  assign cfg_o = cfg_q;

  ////////////////////////////////////////////////////////////////////
  // window decision
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      // look start_delay samples ahead of the sample in hist_i
      tap_idx[c] = TAP_W'(MAX_DELAY_CYCLES - int'(cfg_q.start_delay[c]));
      tapped[c] = trig_taps[tap_idx[c]][c];
      keep[c] = cfg_q.disable_bit[c] | tapped[c] | ((hold_q[c] != '0) & ~first);
      stamp[c] = ~cfg_q.disable_bit[c] & keep[c] & (~prev_keep_q[c] | first);
      if (tapped[c]) begin
        hold_d[c] = hold_t'(cfg_q.start_delay[c]) + hold_t'(cfg_q.stop_delay[c]);
      end else if (first || hold_q[c] == '0) begin
        hold_d[c] = '0;
      end else begin
        hold_d[c] = hold_q[c] - 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      // every channel starts out disabled
      cfg_q <= '0;
      cfg_q.disable_bit <= '1;
      trig_q <= '0;
      rs_q <= '0;
      hold_q <= '0;
      prev_keep_q <= '0;
      data_valid_o <= '0;
      stamp_valid_o <= '0;
    end else begin
      if (cfg_load_i) begin
        cfg_q <= cfg_i;
      end
      trig_q <= {trig_q[MAX_DELAY_CYCLES-2:0], sel_trig_i};
      rs_q <= {rs_q[MAX_DELAY_CYCLES-1:0], reset_state_i};
      hold_q <= hold_d;
      prev_keep_q <= keep & {CHANNELS{hist_valid_i}};
      data_valid_o <= keep & {CHANNELS{hist_valid_i}};
      stamp_valid_o <= stamp & {CHANNELS{hist_valid_i}};
    end
  end

  // payload registers
  always_ff @(posedge adc_clk) begin
    data_o <= hist_i.samples;
    for (int c = 0; c < CHANNELS; c++) begin
      stamps_o[c] <= hist_i.index;
    end
  end

endmodule

// ==== design/sample_history.sv ====
//////////////////////////////////////////////////////////////////////
// sample index counter and fixed-depth delay line of indexed samples
// covers the pre-trigger span so the window can open before the trigger
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sample_history #(
  parameter int MAX_DELAY_CYCLES = 16
) (
  input  logic                        adc_clk,
  input  logic                        reset_i,
  input  logic                        reset_state_i,
  input  disc_types_pkg::sample_vec_t samples_i,
  output disc_types_pkg::hist_t       hist_o,
  output logic                        hist_valid_o
);

  import disc_types_pkg::*;

  localparam int STAGES = MAX_DELAY_CYCLES + 1;

  index_t           index_q;
  index_t           index_cur;
  hist_t            stage_q [STAGES];
  logic [STAGES-1:0] valid_q;

  // the reset_state sample itself gets index 0
  assign index_cur = reset_state_i ? '0 : index_q;

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      index_q <= '0;
      valid_q <= '0;
    end else begin
      index_q <= index_cur + 1'b1;
      valid_q <= {valid_q[STAGES-2:0], 1'b1};
    end
  end

  always_ff @(posedge adc_clk) begin
    stage_q[0] <= '{samples: samples_i, index: index_cur};
    for (int k = 1; k < STAGES; k++) begin
      stage_q[k] <= stage_q[k-1];
    end
  end

  assign hist_o = stage_q[STAGES-1];
  assign hist_valid_o = valid_q[STAGES-1];

endmodule

// ==== design/trigger_router.sv ====
//////////////////////////////////////////////////////////////////////
// digital trigger delay line and per-channel trigger source select
// output is combinational over the delay taps and the analog triggers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module trigger_router #(
  parameter int MAX_DELAY_CYCLES = 16
) (
  input  logic                                    adc_clk,
  input  logic                                    reset_i,
  input  logic [disc_types_pkg::DIG_CHANNELS-1:0] digital_trigger_i,
  input  logic [disc_types_pkg::CHANNELS-1:0]     analog_trig_i,
  input  disc_config_pkg::delay_vec_t             digital_delay_i,
  input  disc_config_pkg::src_vec_t               trigger_source_i,
  output logic [disc_types_pkg::CHANNELS-1:0]     sel_trig_o
);

  import disc_types_pkg::*;

  localparam int TAP_W = $clog2(MAX_DELAY_CYCLES);
  localparam int POOL_W = 1 << SRC_WIDTH;

  typedef logic [TAP_W-1:0] tap_t;

  // entry k holds the digital inputs from k+1 cycles back, so entry 0
  // lines up with the one-cycle analog comparator
  logic [MAX_DELAY_CYCLES-1:0][DIG_CHANNELS-1:0] dig_hist_q;

  // per channel, every selectable trigger at its own delay
  logic [CHANNELS-1:0][DIG_CHANNELS-1:0] dig_tap;
  logic [CHANNELS-1:0][POOL_W-1:0]       pool;

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dig_hist_q <= '0;
    end else begin
      dig_hist_q <= {dig_hist_q[MAX_DELAY_CYCLES-2:0], digital_trigger_i};
    end
  end

  ////////////////////////////////////////////////////////////////////
  // source select
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      dig_tap[c] = dig_hist_q[tap_t'(digital_delay_i[c])];
      // unused codes above the digital inputs read as zero
      pool[c] = '0;
      pool[c][CHANNELS-1:0] = analog_trig_i;
      pool[c][CHANNELS +: DIG_CHANNELS] = dig_tap[c];
      sel_trig_o[c] = pool[c][trigger_source_i[c]];
    end
  end

endmodule

// ==== design/hysteresis_trigger.sv ====
//////////////////////////////////////////////////////////////////////
// per-channel analog comparators with hysteresis
// trigger bit follows the sample by one adc_clk cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hysteresis_trigger (
  input  logic                                adc_clk,
  input  logic                                reset_i,
  input  logic                                reset_state_i,
  input  disc_types_pkg::sample_vec_t         samples_i,
  input  disc_types_pkg::sample_vec_t         low_threshold_i,
  input  disc_types_pkg::sample_vec_t         high_threshold_i,
  output logic [disc_types_pkg::CHANNELS-1:0] analog_trig_o
);

  import disc_types_pkg::*;

  logic [CHANNELS-1:0] state_q;
  logic [CHANNELS-1:0] state_d;

  // a reset_state cycle evaluates its sample from a cleared state
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      state_d[c] = reset_state_i ? 1'b0 : state_q[c];
      if (sample_t'(samples_i[c]) > sample_t'(high_threshold_i[c])) begin
        state_d[c] = 1'b1;
      end else if (sample_t'(samples_i[c]) < sample_t'(low_threshold_i[c])) begin
        state_d[c] = 1'b0;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  assign analog_trig_o = state_q;

endmodule

// ==== design/disc_config_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// discriminator configuration word, loaded as one struct on a strobe
//////////////////////////////////////////////////////////////////////
package disc_config_pkg;

  // delay fields are this wide, so a delay is at most 15 samples
  localparam int TIMER_BITS = 4;

  typedef logic [TIMER_BITS-1:0] delay_t;
  typedef delay_t [disc_types_pkg::CHANNELS-1:0] delay_vec_t;
  typedef disc_types_pkg::src_t [disc_types_pkg::CHANNELS-1:0] src_vec_t;

  typedef struct packed {
    // hysteresis thresholds
    disc_types_pkg::sample_vec_t low_threshold;
    disc_types_pkg::sample_vec_t high_threshold;
    // window and digital trigger delays in samples
    delay_vec_t start_delay;
    delay_vec_t stop_delay;
    delay_vec_t digital_delay;
    src_vec_t   trigger_source;
    // set bit passes every sample of that channel
    logic [disc_types_pkg::CHANNELS-1:0] disable_bit;
  } disc_cfg_t;

endpackage

// ==== design/disc_types_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// sample, index and channel types shared by the discriminator RTL
// channel counts and word widths are fixed here for the whole design
//////////////////////////////////////////////////////////////////////
package disc_types_pkg;

  // analog channels and digital trigger inputs
  localparam int CHANNELS = 4;
  localparam int DIG_CHANNELS = 2;

  localparam int SAMPLE_WIDTH = 16;
  localparam int INDEX_WIDTH = 32;

  // one select code per analog channel and per digital input
  localparam int SRC_WIDTH = $clog2(CHANNELS + DIG_CHANNELS);

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [INDEX_WIDTH-1:0] index_t;

  // one adc word, channel 0 in the low bits
  typedef sample_t [CHANNELS-1:0] sample_vec_t;

  // 0..CHANNELS-1 analog, then digital inputs, anything above is unused
  typedef logic [SRC_WIDTH-1:0] src_t;

  // history payload, samples travel with their index
  typedef struct packed {
    sample_vec_t samples;
    index_t      index;
  } hist_t;

  typedef index_t [CHANNELS-1:0] stamp_vec_t;

endpackage
